// ==== rvPkg.sv ====
//########################################
// RV32I subset only: ADD SUB AND OR SLT ADDI LW SW LUI BEQ JAL
// NOP is ADDI x0,x0,0
//########################################
package rvPkg;

	// data and address width
	localparam int xlen = 32;

	// major opcodes of the kept instructions
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOp_t;

	// operand source for execute, memory stage wins over writeback
	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdMem  = 2'd1,
		fwdWb   = 2'd2
	} fwdSel_t;

	// same 32 bits seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2, rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2, rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic       imm12;
			logic [5:0] imm10to5;
			logic [4:0] rs2, rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic       imm11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} uType;
		struct packed {
			logic       imm20;
			logic [9:0] imm10to1;
			logic       imm11;
			logic [7:0] imm19to12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} jType;
	} instr_t;

	// ADDI x0,x0,0
	localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage : rvPkg

// ==== stageRegs.sv ====
//########################################
// stallD low holds a boundary, clear wins over hold
// only fetch/decode can be held
//########################################
`timescale 1ns/100ps

module stageRegs (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     stallD,
	input  logic                     flushD,
	input  logic                     flushE,
	// fetch side
	input  logic [31:0]              instrF,
	input  logic [rvPkg::xlen-1:0]   pcF,
	input  logic [rvPkg::xlen-1:0]   pcPlus4F,
	output rvPkg::instr_t            instrD,
	// decode side
	input  logic                     regWriteD,
	input  logic                     memToRegD,
	input  logic                     memWriteD,
	input  logic                     aluSrcD,
	input  rvPkg::aluOp_t            aluOpD,
	input  logic                     isBranchD,
	input  logic                     isJalD,
	input  logic                     isLuiD,
	input  logic [rvPkg::xlen-1:0]   rd1D,
	input  logic [rvPkg::xlen-1:0]   rd2D,
	input  logic [rvPkg::xlen-1:0]   immD,
	input  logic [4:0]               rs1D,
	input  logic [4:0]               rs2D,
	input  logic [4:0]               rdD,
	output logic                     regWriteE,
	output logic                     memToRegE,
	output logic                     memWriteE,
	output logic                     aluSrcE,
	output rvPkg::aluOp_t            aluOpE,
	output logic                     isBranchE,
	output logic                     isJalE,
	output logic                     isLuiE,
	output logic [rvPkg::xlen-1:0]   rd1E,
	output logic [rvPkg::xlen-1:0]   rd2E,
	output logic [rvPkg::xlen-1:0]   immE,
	output logic [rvPkg::xlen-1:0]   pcE,
	output logic [rvPkg::xlen-1:0]   pcPlus4E,
	output logic [4:0]               rs1E,
	output logic [4:0]               rs2E,
	output logic [4:0]               rdE,
	// execute side
	input  logic [rvPkg::xlen-1:0]   aluOutE,
	input  logic [rvPkg::xlen-1:0]   writeDataE,
	output logic                     regWriteM,
	output logic                     memToRegM,
	output logic                     memWriteM,
	output logic [rvPkg::xlen-1:0]   aluOutM,
	output logic [rvPkg::xlen-1:0]   writeDataM,
	output logic [4:0]               rdM,
	// memory side
	input  logic [rvPkg::xlen-1:0]   readDataM,
	output logic                     regWriteW,
	output logic                     memToRegW,
	output logic [rvPkg::xlen-1:0]   aluOutW,
	output logic [rvPkg::xlen-1:0]   readDataW,
	output logic [4:0]               rdW
);
	import rvPkg::*;

	// decode stage copy of the fetch pc, only needed one stage later
	logic [xlen-1:0] pcD, pcPlus4D;

	// fetch/decode, a cleared slot decodes as NOP
	always_ff @(posedge clk) begin
		if (rst || flushD) begin
			instrD <= nopInstr;
		end else if (stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (stallD) begin
			pcD      <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end

	// decode/execute control, bubble on load-use or taken branch
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			{regWriteE, memToRegE, memWriteE, aluSrcE} <= '0;
			{isBranchE, isJalE, isLuiE} <= '0;
			aluOpE <= aluAdd;
			{rs1E, rs2E, rdE} <= '0;
		end else begin
			{regWriteE, memToRegE, memWriteE, aluSrcE} <=
				{regWriteD, memToRegD, memWriteD, aluSrcD};
			{isBranchE, isJalE, isLuiE} <= {isBranchD, isJalD, isLuiD};
			aluOpE <= aluOpD;
			{rs1E, rs2E, rdE} <= {rs1D, rs2D, rdD};
		end
	end

	// operand payload, meaningless in a bubble
	always_ff @(posedge clk) begin
		rd1E     <= rd1D;
		rd2E     <= rd2D;
		immE     <= immD;
		pcE      <= pcD;
		pcPlus4E <= pcPlus4D;
	end

	// execute/memory
	always_ff @(posedge clk) begin
		if (rst) begin
			{regWriteM, memToRegM, memWriteM} <= '0;
			rdM <= '0;
		end else begin
			{regWriteM, memToRegM, memWriteM} <= {regWriteE, memToRegE, memWriteE};
			rdM <= rdE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM    <= aluOutE;
		writeDataM <= writeDataE;
	end

	// memory/writeback
	always_ff @(posedge clk) begin
		if (rst) begin
			{regWriteW, memToRegW} <= '0;
			rdW <= '0;
		end else begin
			{regWriteW, memToRegW} <= {regWriteM, memToRegM};
			rdW <= rdM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW   <= aluOutM;
		readDataW <= readDataM;
	end

endmodule : stageRegs

// ==== instrDecoder.sv ====
//########################################
// anything outside the kept subset decodes as NOP
// writes to x0 are dropped here
//########################################
`timescale 1ns/100ps

module instrDecoder (
	input  rvPkg::instr_t            instrD,
	output logic                     regWrite,
	output logic                     memToReg,
	output logic                     memWrite,
	output logic                     aluSrc,
	output rvPkg::aluOp_t            aluOp,
	output logic                     isBranch,
	output logic                     isJal,
	output logic                     isLui,
	output logic [4:0]               rs1,
	output logic [4:0]               rs2,
	output logic [4:0]               rd,
	output logic [rvPkg::xlen-1:0]   imm
);
	import rvPkg::*;

	always_comb begin
		// NOP defaults, unused sources stay x0 so no false stall
		{regWrite, memToReg, memWrite, aluSrc} = '0;
		{isBranch, isJal, isLui} = '0;
		aluOp = aluAdd;
		{rs1, rs2, rd} = '0;
		imm = '0;
		case (instrD.rType.opcode)
			opR: begin
				rs1 = instrD.rType.rs1;
				rs2 = instrD.rType.rs2;
				rd  = instrD.rType.rd;
				regWrite = 1'b1;
				case (instrD.rType.funct3)
					3'b000: aluOp = instrD.rType.funct7[5] ? aluSub : aluAdd;
					3'b010: aluOp = aluSlt;
					3'b110: aluOp = aluOr;
					3'b111: aluOp = aluAnd;
					default: regWrite = 1'b0;
				endcase
			end
			opImm, opLoad: begin
				// ADDI and LW share the I-type view
				rs1 = instrD.iType.rs1;
				rd  = instrD.iType.rd;
				imm = {{20{instrD.iType.imm[11]}}, instrD.iType.imm};
				aluSrc = 1'b1;
				if (instrD.iType.funct3 == 3'b000 && instrD.iType.opcode == opImm) begin
					regWrite = 1'b1;
				end else if (instrD.iType.funct3 == 3'b010 && instrD.iType.opcode == opLoad) begin
					regWrite = 1'b1;
					memToReg = 1'b1;
				end
			end
			opStore: begin
				rs1 = instrD.sType.rs1;
				rs2 = instrD.sType.rs2;
				imm = {{20{instrD.sType.immHi[6]}}, instrD.sType.immHi, instrD.sType.immLo};
				aluSrc = 1'b1;
				// word stores only
				memWrite = (instrD.sType.funct3 == 3'b010);
			end
			opLui: begin
				rd = instrD.uType.rd;
				imm = {instrD.uType.imm, 12'b0};
				regWrite = 1'b1;
				isLui = 1'b1;
			end
			opBranch: begin
				rs1 = instrD.bType.rs1;
				rs2 = instrD.bType.rs2;
				imm = {{19{instrD.bType.imm12}}, instrD.bType.imm12, instrD.bType.imm11,
					instrD.bType.imm10to5, instrD.bType.imm4to1, 1'b0};
				// BEQ only
				isBranch = (instrD.bType.funct3 == 3'b000);
			end
			opJal: begin
				rd = instrD.jType.rd;
				imm = {{11{instrD.jType.imm20}}, instrD.jType.imm20, instrD.jType.imm19to12,
					instrD.jType.imm11, instrD.jType.imm10to1, 1'b0};
				regWrite = 1'b1;
				isJal = 1'b1;
			end
			default: ;
		endcase
		// x0 is never a real destination
		if (rd == 5'd0) begin
			regWrite = 1'b0;
		end
	end

endmodule : instrDecoder

// ==== regFile.sv ====
//########################################
// all registers clear on reset
// same-cycle write is visible on the reads
//########################################
`timescale 1ns/100ps

module regFile (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [4:0]               ra1,
	input  logic [4:0]               ra2,
	output logic [rvPkg::xlen-1:0]   rd1,
	output logic [rvPkg::xlen-1:0]   rd2,
	input  logic                     we,
	input  logic [4:0]               wa,
	input  logic [rvPkg::xlen-1:0]   wd
);
	import rvPkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// writeback bypass, x0 hardwired
	assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule : regFile

// ==== execUnit.sv ====
//########################################
// BEQ and JAL resolve here, target is pc + imm
// JAL link value rides on the ALU result
//########################################
`timescale 1ns/100ps

module execUnit (
	input  logic [rvPkg::xlen-1:0]   rd1E,
	input  logic [rvPkg::xlen-1:0]   rd2E,
	input  logic [rvPkg::xlen-1:0]   immE,
	input  logic [rvPkg::xlen-1:0]   pcE,
	input  logic [rvPkg::xlen-1:0]   pcPlus4E,
	input  rvPkg::aluOp_t            aluOpE,
	input  logic                     aluSrcE,
	input  logic                     isBranchE,
	input  logic                     isJalE,
	input  logic                     isLuiE,
	input  rvPkg::fwdSel_t           fwdA,
	input  rvPkg::fwdSel_t           fwdB,
	input  logic [rvPkg::xlen-1:0]   aluOutM,
	input  logic [rvPkg::xlen-1:0]   resultW,
	output logic [rvPkg::xlen-1:0]   aluOutE,
	output logic [rvPkg::xlen-1:0]   writeDataE,
	output logic                     takenE,
	output logic [rvPkg::xlen-1:0]   targetE
);
	import rvPkg::*;

	logic [xlen-1:0] srcA, srcB, aluRes;

	// forwarding muxes
	always_comb begin
		case (fwdA)
			fwdMem:  srcA = aluOutM;
			fwdWb:   srcA = resultW;
			default: srcA = rd1E;
		endcase
		case (fwdB)
			fwdMem:  writeDataE = aluOutM;
			fwdWb:   writeDataE = resultW;
			default: writeDataE = rd2E;
		endcase
	end

	// store data keeps the register operand, ALU may take the immediate
	assign srcB = aluSrcE ? immE : writeDataE;

	always_comb begin
		case (aluOpE)
			aluSub:  aluRes = srcA - srcB;
			aluAnd:  aluRes = srcA & srcB;
			aluOr:   aluRes = srcA | srcB;
			aluSlt:  aluRes = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluRes = srcA + srcB;
		endcase
	end

	// LUI passes the shifted immediate, JAL writes the link
	assign aluOutE = isJalE ? pcPlus4E : (isLuiE ? immE : aluRes);

	// BEQ compares the forwarded register operands
	assign takenE  = isJalE || (isBranchE && srcA == writeDataE);
	assign targetE = pcE + immE;

endmodule : execUnit

// ==== hazardCtrl.sv ====
//########################################
// stall outputs are active-low holds, low freezes fetch and decode
// loads never forward from memory stage, they stall
//########################################
`timescale 1ns/100ps

module hazardCtrl (
	input  logic [4:0]       rs1D,
	input  logic [4:0]       rs2D,
	input  logic [4:0]       rs1E,
	input  logic [4:0]       rs2E,
	input  logic [4:0]       rdE,
	input  logic             memToRegE,
	input  logic [4:0]       rdM,
	input  logic             regWriteM,
	input  logic [4:0]       rdW,
	input  logic             regWriteW,
	input  logic             takenE,
	output logic             stallF,
	output logic             stallD,
	output logic             flushD,
	output logic             flushE,
	output rvPkg::fwdSel_t   fwdA,
	output rvPkg::fwdSel_t   fwdB
);
	import rvPkg::*;

	logic lwStall;

	// operand forwarding, memory stage first, x0 never forwarded
	always_comb begin
		if (rs1E != 5'd0 && regWriteM && rs1E == rdM) begin
			fwdA = fwdMem;
		end else if (rs1E != 5'd0 && regWriteW && rs1E == rdW) begin
			fwdA = fwdWb;
		end else begin
			fwdA = fwdNone;
		end
		if (rs2E != 5'd0 && regWriteM && rs2E == rdM) begin
			fwdB = fwdMem;
		end else if (rs2E != 5'd0 && regWriteW && rs2E == rdW) begin
			fwdB = fwdWb;
		end else begin
			fwdB = fwdNone;
		end
	end

	// load in execute whose result a decode source needs
	assign lwStall = memToRegE && rdE != 5'd0 && (rdE == rs1D || rdE == rs2D);

	// hold fetch and decode for one cycle
	assign stallF = !lwStall;
	assign stallD = !lwStall;

	// taken branch drops both younger slots, a stall leaves a bubble in execute
	assign flushD = takenE;
	assign flushE = takenE || lwStall;

endmodule : hazardCtrl

// ==== riscvCore.sv ====
//########################################
// memories sit outside and answer in the same cycle
// dmemWe is a one-cycle strobe, word access only
//########################################
`timescale 1ns/100ps

module riscvCore (
	input  logic                     clk,
	input  logic                     rst,
	output logic [rvPkg::xlen-1:0]   imemAddr,
	input  logic [31:0]              instr,
	output logic [rvPkg::xlen-1:0]   dmemAddr,
	output logic [rvPkg::xlen-1:0]   dmemWrData,
	output logic                     dmemWe,
	input  logic [rvPkg::xlen-1:0]   dmemRdData,
	output logic                     retireEn,
	output logic [4:0]               retireReg,
	output logic [rvPkg::xlen-1:0]   retireData
);
	import rvPkg::*;

	// fetch
	logic [xlen-1:0] pcF, pcPlus4F;
	// decode
	instr_t          instrD;
	logic            regWriteD, memToRegD, memWriteD, aluSrcD;
	aluOp_t          aluOpD;
	logic            isBranchD, isJalD, isLuiD;
	logic [4:0]      rs1D, rs2D, rdD;
	logic [xlen-1:0] rd1D, rd2D, immD;
	// execute
	logic            regWriteE, memToRegE, memWriteE, aluSrcE;
	aluOp_t          aluOpE;
	logic            isBranchE, isJalE, isLuiE;
	logic [4:0]      rs1E, rs2E, rdE;
	logic [xlen-1:0] rd1E, rd2E, immE, pcE, pcPlus4E;
	logic [xlen-1:0] aluOutE, writeDataE, targetE;
	logic            takenE;
	// memory
	logic            regWriteM, memToRegM, memWriteM;
	logic [4:0]      rdM;
	logic [xlen-1:0] aluOutM, writeDataM;
	// writeback
	logic            regWriteW, memToRegW;
	logic [4:0]      rdW;
	logic [xlen-1:0] aluOutW, readDataW, resultW;
	// hazard control
	logic            stallF, stallD, flushD, flushE;
	fwdSel_t         fwdA, fwdB;

	// pc, a taken branch overrides a stall, stallF low holds
	always_ff @(posedge clk) begin
		if (rst) begin
			pcF <= '0;
		end else if (takenE) begin
			pcF <= targetE;
		end else if (stallF) begin
			pcF <= pcPlus4F;
		end
	end

	assign pcPlus4F = pcF + 32'd4;
	assign imemAddr = pcF;

	stageRegs stageRegs_i (
		.clk, .rst, .stallD, .flushD, .flushE,
		.instrF(instr), .pcF, .pcPlus4F, .instrD,
		.regWriteD, .memToRegD, .memWriteD, .aluSrcD, .aluOpD,
		.isBranchD, .isJalD, .isLuiD, .rd1D, .rd2D, .immD, .rs1D, .rs2D, .rdD,
		.regWriteE, .memToRegE, .memWriteE, .aluSrcE, .aluOpE,
		.isBranchE, .isJalE, .isLuiE, .rd1E, .rd2E, .immE, .pcE, .pcPlus4E,
		.rs1E, .rs2E, .rdE,
		.aluOutE, .writeDataE,
		.regWriteM, .memToRegM, .memWriteM, .aluOutM, .writeDataM, .rdM,
		.readDataM(dmemRdData),
		.regWriteW, .memToRegW, .aluOutW, .readDataW, .rdW
	);

	instrDecoder instrDecoder_i (
		.instrD,
		.regWrite(regWriteD), .memToReg(memToRegD), .memWrite(memWriteD),
		.aluSrc(aluSrcD), .aluOp(aluOpD),
		.isBranch(isBranchD), .isJal(isJalD), .isLui(isLuiD),
		.rs1(rs1D), .rs2(rs2D), .rd(rdD), .imm(immD)
	);

	// written from writeback, read in decode
	regFile regFile_i (
		.clk, .rst,
		.ra1(rs1D), .ra2(rs2D), .rd1(rd1D), .rd2(rd2D),
		.we(regWriteW), .wa(rdW), .wd(resultW)
	);

	execUnit execUnit_i (
		.rd1E, .rd2E, .immE, .pcE, .pcPlus4E, .aluOpE, .aluSrcE,
		.isBranchE, .isJalE, .isLuiE, .fwdA, .fwdB, .aluOutM, .resultW,
		.aluOutE, .writeDataE, .takenE, .targetE
	);

	hazardCtrl hazardCtrl_i (
		.rs1D, .rs2D, .rs1E, .rs2E, .rdE, .memToRegE,
		.rdM, .regWriteM, .rdW, .regWriteW, .takenE,
		.stallF, .stallD, .flushD, .flushE, .fwdA, .fwdB
	);

	// memory stage drives the data port directly
	assign dmemAddr   = aluOutM;
	assign dmemWrData = writeDataM;
	assign dmemWe     = memWriteM;

	// writeback select
	assign resultW = memToRegW ? readDataW : aluOutW;

	// retire port mirrors the register file write
	assign retireEn   = regWriteW;
	assign retireReg  = rdW;
	assign retireData = resultW;

endmodule : riscvCore

// ==== tbClock.sv ====
//########################################
// 10 ns clock, power-on reset for 3 cycles
//########################################
`timescale 1ns/100ps

module tbClock (
	output logic clk,
	output logic porRst
);
	initial begin
		clk = 1'b0;
		porRst = 1'b1;
		forever #5 clk = ~clk;
	end

	// release on a falling edge, after three rising edges
	initial begin
		repeat (3) @(posedge clk);
		@(negedge clk);
		porRst = 1'b0;
	end
endmodule : tbClock

// ==== coreTb_chk.sv ====
//########################################
// bound into riscvCore, uses its internal names
// load-use check assumes no taken branch right after
//########################################
`timescale 1ns/100ps

module coreTb_chk (
	input logic                   clk,
	input logic                   rst,
	input logic                   retireEn,
	input logic [4:0]             retireReg,
	input logic [31:0]            retireData,
	input logic                   dmemWe,
	input logic                   takenE,
	input logic [31:0]            pcF,
	input logic                   memToRegE,
	input logic [4:0]             rdE,
	input logic [4:0]             rs1D,
	input logic [4:0]             rs2D
);
	logic loadUse;

	// load in execute feeding a decode source
	assign loadUse = memToRegE && rdE != 5'd0 && (rdE == rs1D || rdE == rs2D);

	quietAfterReset: assert property (@(posedge clk) rst |=> !retireEn && !dmemWe)
		else $error("retire or store strobe high right after reset");

	noX0Retire: assert property (@(posedge clk) disable iff (rst)
		retireEn |-> retireReg != 5'd0)
		else $error("retire to x0");

	// branch in execute retires two cycles later, its two younger slots after that
	flushedSlots: assert property (@(posedge clk) disable iff (rst)
		takenE |-> ##3 !retireEn ##1 !retireEn)
		else $error("flushed slot retired after taken branch");

	retireKnown: assert property (@(posedge clk) disable iff (rst)
		retireEn |-> !$isunknown(retireData))
		else $error("retire data unknown");

	// exactly one held cycle
	loadUseHold: assert property (@(posedge clk) disable iff (rst)
		loadUse && !takenE |=> (pcF == $past(pcF)) ##1 (pcF != $past(pcF)))
		else $error("pc hold after load-use not one cycle");
endmodule : coreTb_chk

bind riscvCore coreTb_chk chk_i (.*);

// ==== coreTb.sv ====
//########################################
// memories are 64 words, addresses wrap
// programs end in JAL x0,0 which the model treats as halt
//########################################
`timescale 1ns/100ps

module coreTb;
	import rvPkg::*;

	logic clk, porRst, testRst, rst;
	logic [31:0] imemAddr, instr, dmemAddr, dmemWrData, dmemRdData, retireData;
	logic dmemWe, retireEn;
	logic [4:0] retireReg;
	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] seed;
	// expected stores as {addr, data}, retires as {reg, data}
	logic [63:0] stQ[$];
	logic [36:0] retQ[$];
	int stIdx, retIdx, errors, testErrors, tests, pc;
	bit active;

	tbClock clkGen (.clk, .porRst);

	riscvCore dut_i (
		.clk, .rst, .imemAddr, .instr, .dmemAddr, .dmemWrData, .dmemWe,
		.dmemRdData, .retireEn, .retireReg, .retireData
	);

	assign instr = imem[imemAddr[7:2]];
	assign dmemRdData = dmem[dmemAddr[7:2]];

	initial begin
		testRst = 1'b0;
	end
	// both reset sources change on falling edges
	assign rst = porRst || testRst;

	function automatic logic [31:0] lcgNext();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, int rd, rs1, rs2);
		instr_t w;
		w.rType = '{f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opR};
		return w;
	endfunction

	function automatic logic [31:0] encI(logic [6:0] op, int rd, rs1, logic [11:0] imm);
		instr_t w;
		w.iType = '{imm, rs1[4:0], (op == opLoad) ? 3'b010 : 3'b000, rd[4:0], op};
		return w;
	endfunction

	function automatic logic [31:0] encS(int rs2, rs1, logic [11:0] imm);
		instr_t w;
		w.sType = '{imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
		return w;
	endfunction

	function automatic logic [31:0] encB(int rs1, rs2, logic [12:0] imm);
		instr_t w;
		w.bType = '{imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
			opBranch};
		return w;
	endfunction

	function automatic logic [31:0] encU(int rd, logic [19:0] imm);
		instr_t w;
		w.uType = '{imm, rd[4:0], opLui};
		return w;
	endfunction

	function automatic logic [31:0] encJ(int rd, logic [20:0] imm);
		instr_t w;
		w.jType = '{imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
		return w;
	endfunction

	task automatic put(logic [31:0] w);
		imem[pc] = w;
		pc++;
	endtask

	// reference interpreter straight from the ISA rules
	task automatic refRun();
		logic [31:0] x [32];
		logic [31:0] w, iImm, sImm, bImm, jImm, a, b, r, p;
		int rd;
		bit wr;
		for (int i = 0; i < 32; i++) x[i] = '0;
		p = '0;
		for (int step = 0; step < 300; step++) begin
			w = imem[p[7:2]];
			iImm = {{20{w[31]}}, w[31:20]};
			sImm = {{20{w[31]}}, w[31:25], w[11:7]};
			bImm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			jImm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			a = x[w[19:15]];
			b = x[w[24:20]];
			rd = w[11:7];
			wr = 1'b1;
			r = '0;
			if (w[6:0] == opJal && jImm == 0) break;
			case (w[6:0])
				opR: case (w[14:12])
					3'b000: r = w[30] ? a - b : a + b;
					3'b010: r = ($signed(a) < $signed(b)) ? 1 : 0;
					3'b110: r = a | b;
					default: r = a & b;
				endcase
				opImm: r = a + iImm;
				opLoad: r = dmem[(a + iImm) >> 2 & 63];
				opLui: r = {w[31:12], 12'b0};
				opJal: r = p + 4;
				default: wr = 1'b0;
			endcase
			if (w[6:0] == opStore) begin
				stQ.push_back({a + sImm, b});
				dmem[(a + sImm) >> 2 & 63] = b;
			end
			if (wr && rd != 0) begin
				x[rd] = r;
				retQ.push_back({rd[4:0], r});
			end
			if (w[6:0] == opJal) p = p + jImm;
			else if (w[6:0] == opBranch && a == b) p = p + bImm;
			else p = p + 4;
		end
	endtask

	task automatic fillDmem();
		for (int i = 0; i < 64; i++) dmem[i] = i * 32'h0101_0101 ^ 32'h5a00_00a5;
	endtask

	// checks stores and retires in program order
	always @(posedge clk) begin
		if (active && !rst) begin
			if (dmemWe) begin
				assert (stIdx < stQ.size() && {dmemAddr, dmemWrData} == stQ[stIdx]) else begin
					if (stIdx < stQ.size())
						$display("ERR %0t dmemAddr/dmemWrData exp %h got %h", $time,
							stQ[stIdx], {dmemAddr, dmemWrData});
					else
						$display("unexpected store at %0t to address %h", $time, dmemAddr);
					testErrors++;
				end
				dmem[dmemAddr[7:2]] <= dmemWrData;
				stIdx++;
			end
			if (retireEn) begin
				assert (retIdx < retQ.size() && {retireReg, retireData} == retQ[retIdx]) else begin
					if (retIdx < retQ.size())
						$display("ERR %0t retireReg/retireData exp %h got %h", $time,
							retQ[retIdx], {retireReg, retireData});
					else
						$display("unexpected retire at %0t of x%0d", $time, retireReg);
					testErrors++;
				end
				retIdx++;
			end
		end
	end

	task automatic runTest(string name);
		int cycles;
		put(encJ(0, 0));
		stQ.delete();
		retQ.delete();
		fillDmem();
		refRun();
		fillDmem();
		stIdx = 0;
		retIdx = 0;
		testErrors = 0;
		@(negedge clk);
		testRst = 1'b1;
		repeat (3) @(negedge clk);
		testRst = 1'b0;
		active = 1'b1;
		cycles = 0;
		while (stIdx < stQ.size() || retIdx < retQ.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > 300) begin
				$display("test %s hung: only %0d of %0d retires seen", name, retIdx, retQ.size());
				$display(">>> FAIL");
				$finish;
			end
		end
		// let any wrongly kept slot show up
		repeat (8) @(negedge clk);
		active = 1'b0;
		tests++;
		errors += testErrors;
		$display("test %s done, %0d errors", name, testErrors);
	endtask

	initial begin
		int porCycles;
		seed = 32'h95d2;
		active = 1'b0;
		errors = 0;
		tests = 0;
		for (int i = 0; i < 64; i++) imem[i] = nopInstr;
		fillDmem();
		porCycles = 0;
		while (porRst) begin
			@(negedge clk);
			porCycles++;
			if (porCycles > 20) begin
				$display("power-on reset was never released");
				$display(">>> FAIL");
				$finish;
			end
		end

		pc = 0;
		put(encI(opImm, 1, 0, lcgNext()));
		put(encU(2, lcgNext()));
		put(encI(opImm, 2, 2, lcgNext()));
		put(encR(7'h00, 3'b000, 3, 1, 2));
		put(encR(7'h20, 3'b000, 4, 1, 2));
		put(encR(7'h00, 3'b111, 5, 1, 2));
		put(encR(7'h00, 3'b110, 6, 1, 2));
		put(encR(7'h00, 3'b010, 7, 1, 2));
		for (int r = 1; r < 8; r++) put(encS(r, 0, r * 4));
		runTest("alu");

		pc = 0;
		put(encI(opImm, 1, 0, lcgNext()));
		put(encR(7'h00, 3'b000, 2, 1, 1));
		put(encI(opImm, 3, 0, lcgNext()));
		put(encR(7'h20, 3'b000, 4, 2, 1));
		put(encI(opImm, 5, 0, 1));
		put(encR(7'h00, 3'b110, 6, 3, 2));
		put(encS(6, 0, 40));
		runTest("forward");

		pc = 0;
		put(encI(opImm, 1, 0, lcgNext()));
		put(encS(1, 0, 8));
		put(encI(opLoad, 4, 0, 8));
		put(encR(7'h00, 3'b000, 5, 4, 1));
		put(encS(5, 0, 12));
		put(encI(opLoad, 6, 0, 20));
		put(encR(7'h00, 3'b000, 7, 1, 6));
		runTest("loaduse");

		pc = 0;
		put(encI(opImm, 1, 0, 5));
		put(encI(opImm, 2, 0, 9));
		put(encB(1, 1, 12));
		put(encS(1, 0, 0));
		put(encS(1, 0, 4));
		put(encJ(7, 12));
		put(encS(2, 0, 8));
		put(encS(2, 0, 12));
		put(encB(1, 2, 8));
		put(encS(7, 0, 16));
		// taken jump over two slots that would retire
		put(encJ(0, 12));
		put(encI(opImm, 8, 0, 1));
		put(encI(opImm, 9, 0, 2));
		put(encI(opImm, 10, 0, 3));
		runTest("flush");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// overall guard
	initial begin
		#200000;
		$display("simulation ran out of time");
		$display(">>> FAIL");
		$finish;
	end
endmodule : coreTb

// ==== flist.f ====
rvPkg.sv
stageRegs.sv
instrDecoder.sv
regFile.sv
execUnit.sv
hazardCtrl.sv
riscvCore.sv
tbClock.sv
coreTb_chk.sv
coreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module coreTb -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q ">>> PASS"; then
	exit 0
fi
exit 1
